/* Makefile */
# Verilator build and run for the ADC snapshot project
# usage: make [run|lint|clean] [VAR=value ...]

VERILATOR ?= verilator
TOP       ?= tb_adc_snapshot
LINT_TOP  ?= adc_snapshot_top
FILELIST  ?= adc_snapshot.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing -j $(JOBS)
LINTFLAGS ?= --lint-only -Wall --timing

PASS_TEXT := Done: no errors
SOURCES   := $(shell cat $(FILELIST))
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* adc_snapshot.f */
src/adc_pkg.sv
src/sample_stage.sv
src/addr_counter.sv
src/capture_fsm.sv
src/sample_buffer.sv
src/adc_snapshot_top.sv
test/snapshot_checker.sv
test/tb_adc_snapshot.sv

/* src/adc_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ADC snapshot package
// word widths, buffer depth, capture latency and buffer entry types
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package adc_pkg;

	localparam int ADC_WORD_W = 16;	// raw word from the deserializer
	localparam int SAMPLE_W = 14;	// offset-binary bits actually used
	localparam int SAMPLE_LSB = 2;	// bottom two bits are zero padding

	localparam int SNAP_ADDR_W = 10;
	localparam int SNAP_DEPTH = 1 << SNAP_ADDR_W;

	localparam int RESULT_W = 32;	// one correlator power word

	// edges from the first high enable sample E to the write of entry 0
	localparam int CAPTURE_LAT = 5;

	typedef logic signed [ADC_WORD_W-1:0] sample_t;

	// ch0 in the upper half
	typedef struct packed {
		sample_t ch0;
		sample_t ch1;
	} sample_pair_t;

	// bb in the upper half
	typedef struct packed {
		logic [RESULT_W-1:0] bb;
		logic [RESULT_W-1:0] aa;
	} result_pair_t;

	typedef logic [SNAP_ADDR_W-1:0] addr_t;

endpackage

/* src/adc_snapshot_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ADC snapshot top
// dual-channel sample snapshot on enable, plus a log of correlator powers
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module adc_snapshot_top
	import adc_pkg::*;
(
	input  logic                  data_clk_div,
	input  logic                  reset,

	input  logic [ADC_WORD_W-1:0] adc0_data,
	input  logic [ADC_WORD_W-1:0] adc1_data,
	input  logic                  enable_bram,	// async level

	input  logic                  corr_valid,	// one cycle per result
	input  logic [RESULT_W-1:0]   corr_aa,
	input  logic [RESULT_W-1:0]   corr_bb,

	input  addr_t                 snap_rd_addr,
	output sample_pair_t          snap_rd_data,
	input  addr_t                 result_rd_addr,
	output result_pair_t          result_rd_data,

	output logic                  capture_done
);

	sample_pair_t pair;

	logic  snap_clear;
	logic  snap_advance;
	logic  snap_we;
	logic  snap_last;
	addr_t snap_addr;

	addr_t        result_addr;
	result_pair_t result_entry;

	sample_stage i_sample_stage (
		.data_clk_div (data_clk_div),
		.adc0_data    (adc0_data),
		.adc1_data    (adc1_data),
		.pair         (pair)
	);

	capture_fsm i_capture_fsm (
		.data_clk_div (data_clk_div),
		.reset        (reset),
		.enable_bram  (enable_bram),
		.last         (snap_last),
		.clear        (snap_clear),
		.advance      (snap_advance),
		.write_en     (snap_we),
		.capture_done (capture_done)
	);

	addr_counter i_snap_counter (
		.data_clk_div (data_clk_div),
		.reset        (reset),
		.clear        (snap_clear),
		.advance      (snap_advance),
		.addr         (snap_addr),
		.last         (snap_last)
	);

	sample_buffer #(
		.entry_t (sample_pair_t)
	) i_snap_buffer (
		.data_clk_div (data_clk_div),
		.write_en     (snap_we),
		.write_addr   (snap_addr),
		.write_data   (pair),
		.read_addr    (snap_rd_addr),
		.read_data    (snap_rd_data)
	);

	// free-running result log that wraps over the oldest
	addr_counter i_result_counter (
		.data_clk_div (data_clk_div),
		.reset        (reset),
		.clear        (1'b0),
		.advance      (corr_valid),
		.addr         (result_addr),
		.last         ()
	);

	assign result_entry = '{bb: corr_bb, aa: corr_aa};

	sample_buffer #(
		.entry_t (result_pair_t)
	) i_result_buffer (
		.data_clk_div (data_clk_div),
		.write_en     (corr_valid),
		.write_addr   (result_addr),
		.write_data   (result_entry),
		.read_addr    (result_rd_addr),
		.read_data    (result_rd_data)
	);

endmodule

/* src/addr_counter.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Buffer write-address counter
// clear, advance with wrap, and a flag on the last address
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module addr_counter
	import adc_pkg::*;
(
	input  logic  data_clk_div,
	input  logic  reset,
	input  logic  clear,
	input  logic  advance,
	output addr_t addr,
	output logic  last
);

	localparam addr_t LAST_ADDR = addr_t'(SNAP_DEPTH - 1);

	always_ff @(posedge data_clk_div) begin
		if (reset || clear) begin
			addr <= '0;
		end else if (advance) begin
			if (addr == LAST_ADDR)
				addr <= '0;	// wrap so the oldest entry goes next
			else
				addr <= addr + addr_t'(1);
		end
	end

	assign last = (addr == LAST_ADDR);

endmodule

/* src/capture_fsm.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Snapshot capture FSM
// syncs the enable level, arms on its rising edge and fills one buffer pass
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module capture_fsm (
	input  logic data_clk_div,
	input  logic reset,
	input  logic enable_bram,
	input  logic last,
	output logic clear,
	output logic advance,
	output logic write_en,
	output logic capture_done
);

	typedef enum logic [1:0] {
		st_idle,
		st_arm,
		st_filling,
		st_full
	} state_t;

	state_t state;
	state_t state_next;

	logic [2:0] en_sync;	// enable_bram is async
	logic en_d;
	logic en_rise;
	logic en_fall;

	assign en_rise = en_sync[2] & ~en_d;
	assign en_fall = ~en_sync[2] & en_d;

	always_ff @(posedge data_clk_div) begin
		if (reset) begin
			en_sync <= '0;
			en_d <= 1'b0;
			state <= st_idle;
		end else begin
			en_sync <= {en_sync[1:0], enable_bram};
			en_d <= en_sync[2];
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				if (en_rise)
					state_next = st_arm;
			end
			st_arm: begin
				state_next = st_filling;	// counter cleared here
			end
			st_filling: begin
				if (last)
					state_next = st_full;	// this write is the final entry
			end
			st_full: begin
				state_next = st_full;	// hold until enable drops
			end
			default: begin
				state_next = st_idle;
			end
		endcase

		// enable low aborts or ends any capture
		if (en_fall)
			state_next = st_idle;
	end

	assign clear = (state == st_arm);
	assign write_en = (state == st_filling);
	assign advance = (state == st_filling);
	assign capture_done = (state == st_full);

endmodule

/* src/sample_buffer.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sample buffer
// one write port and one registered read port, entry type set per instance
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module sample_buffer
	import adc_pkg::*;
#(
	parameter type entry_t = sample_pair_t
) (
	input  logic   data_clk_div,
	input  logic   write_en,
	input  addr_t  write_addr,
	input  entry_t write_data,
	input  addr_t  read_addr,
	output entry_t read_data
);

	entry_t mem [SNAP_DEPTH];

	always_ff @(posedge data_clk_div) begin
		if (write_en)
			mem[write_addr] <= write_data;
	end

	// data one cycle after the address
	always_ff @(posedge data_clk_div) begin
		read_data <= mem[read_addr];
	end

endmodule

/* src/sample_stage.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sample stage
// offset-binary ADC words to signed samples, both channels paired in one reg
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module sample_stage
	import adc_pkg::*;
(
	input  logic                  data_clk_div,
	input  logic [ADC_WORD_W-1:0] adc0_data,
	input  logic [ADC_WORD_W-1:0] adc1_data,
	output sample_pair_t          pair
);

	// flip the msb of the field, then sign extend
	function automatic sample_t to_signed(input logic [ADC_WORD_W-1:0] word);
		logic [SAMPLE_W-1:0] field;
		logic signed [SAMPLE_W-1:0] twos;
		begin
			field = word[SAMPLE_LSB +: SAMPLE_W];
			twos = {~field[SAMPLE_W-1], field[SAMPLE_W-2:0]};
			to_signed = sample_t'(twos);
		end
	endfunction

	sample_t ch0_signed;
	sample_t ch1_signed;

	// each channel from its own word
	always_comb begin
		ch0_signed = to_signed(adc0_data);
		ch1_signed = to_signed(adc1_data);
	end

	always_ff @(posedge data_clk_div) begin
		pair.ch0 <= ch0_signed;
		pair.ch1 <= ch1_signed;
	end

endmodule

/* test/snapshot_checker.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Snapshot checker
// models expected buffer contents from the DUT ports and compares readback
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module snapshot_checker
	import adc_pkg::*;
(
	input  logic                  data_clk_div,
	input  logic                  reset,
	input  logic [ADC_WORD_W-1:0] adc0_data,
	input  logic [ADC_WORD_W-1:0] adc1_data,
	input  logic                  enable_bram,
	input  logic                  corr_valid,
	input  logic [RESULT_W-1:0]   corr_aa,
	input  logic [RESULT_W-1:0]   corr_bb,
	input  addr_t                 snap_rd_addr,
	input  sample_pair_t          snap_rd_data,
	input  addr_t                 result_rd_addr,
	input  result_pair_t          result_rd_data,
	input  logic                  capture_done,
	input  logic                  snap_rd_en,
	input  logic                  result_rd_en,
	input  logic                  test_end,
	input  int                    test_id,
	output int                    checks,
	output int                    errors
);

	logic [ADC_WORD_W-1:0] raw0_q[$];	// words seen from edge E on
	logic [ADC_WORD_W-1:0] raw1_q[$];
	result_pair_t res_exp [SNAP_DEPTH];
	addr_t res_wr = '0;

	logic en_prev = 1'b0;
	logic reset_s = 1'b1;
	logic capturing = 1'b0;
	logic snap_pend = 1'b0;
	logic res_pend = 1'b0;
	logic done_prev = 1'b0;
	addr_t snap_pend_addr;
	addr_t res_pend_addr;
	int since_e = 0;
	int en_low_run = 0;
	int en_high_run = 0;
	int idx;
	int n_checks = 0;
	int n_errors = 0;
	int checks_mark = 0;
	int errors_mark = 0;
	sample_pair_t snap_want;

	assign checks = n_checks;
	assign errors = n_errors;

	// offset binary is the code minus half scale
	function automatic sample_t sample_ref(input logic [ADC_WORD_W-1:0] word);
		int v;
		v = int'(word[SAMPLE_LSB +: SAMPLE_W]) - (1 << (SAMPLE_W - 1));
		return sample_t'(v);
	endfunction

	function automatic sample_pair_t pair_ref(input logic [ADC_WORD_W-1:0] w0,
			input logic [ADC_WORD_W-1:0] w1);
		sample_pair_t p;
		p.ch0 = sample_ref(w0);
		p.ch1 = sample_ref(w1);
		return p;
	endfunction

	function automatic result_pair_t result_ref(input logic [RESULT_W-1:0] aa,
			input logic [RESULT_W-1:0] bb);
		result_pair_t r;
		r.bb = bb;
		r.aa = aa;
		return r;
	endfunction

	// sample the inputs where the testbench holds them still
	always @(posedge data_clk_div) begin
		reset_s = reset;
		if (enable_bram && !en_prev && !reset) begin
			raw0_q.delete();
			raw1_q.delete();
			since_e = 0;
			capturing = 1'b1;
		end else if (capturing) begin
			if (since_e == CAPTURE_LAT + SNAP_DEPTH)
				capturing = 1'b0;
			else
				since_e++;
		end
		if (raw0_q.size() < CAPTURE_LAT - 1 + SNAP_DEPTH) begin
			raw0_q.push_back(adc0_data);
			raw1_q.push_back(adc1_data);
		end
		en_low_run = enable_bram ? 0 : en_low_run + 1;
		en_high_run = enable_bram ? en_high_run + 1 : 0;
		en_prev = enable_bram;

		if (reset) begin
			res_wr = '0;
		end else if (corr_valid) begin
			res_exp[res_wr] = result_ref(corr_aa, corr_bb);
			res_wr = res_wr + addr_t'(1);	// wraps like the log
		end

		snap_pend = snap_rd_en;
		snap_pend_addr = snap_rd_addr;
		res_pend = result_rd_en;
		res_pend_addr = result_rd_addr;

		if (test_end) begin
			$display("test %0d finished: %0d checks, %0d errors", test_id,
				n_checks - checks_mark, n_errors - errors_mark);
			checks_mark = n_checks;
			errors_mark = n_errors;
		end
	end

	// outputs settle after the rising edge so compare at the falling one
	always @(negedge data_clk_div) begin
		if (snap_pend) begin
			n_checks++;
			idx = CAPTURE_LAT - 1 + int'(snap_pend_addr);
			if (idx >= raw0_q.size()) begin
				$display("snapshot entry %0d was read before its sample was recorded",
					snap_pend_addr);
				n_errors++;
			end else begin
				snap_want = pair_ref(raw0_q[idx], raw1_q[idx]);
				if (snap_rd_data !== snap_want) begin
					$display("ERROR %0t: snapshot entry %0d is %h, expected %h", $time,
						snap_pend_addr, snap_rd_data, snap_want);
					n_errors++;
				end
			end
		end
		if (res_pend) begin
			n_checks++;
			if (result_rd_data !== res_exp[res_pend_addr]) begin
				$display("ERROR %0t: result entry %0d is %h, expected %h", $time,
					res_pend_addr, result_rd_data, res_exp[res_pend_addr]);
				n_errors++;
			end
		end
		if (capturing && en_high_run == since_e + 1) begin
			n_checks++;
			if (capture_done !== (since_e >= CAPTURE_LAT + SNAP_DEPTH - 1)) begin
				$display("ERROR %0t: capture_done is %b, %0d cycles after enable edge",
					$time, capture_done, since_e);
				n_errors++;
			end
		end
		if (en_low_run >= 5) begin
			n_checks++;
			if (capture_done !== 1'b0) begin
				$display("ERROR %0t: capture_done high with enable_bram low", $time);
				n_errors++;
			end
		end
		if (done_prev === 1'b1 && en_high_run >= 4 && !reset_s) begin
			n_checks++;
			if (capture_done !== 1'b1) begin
				$display("ERROR %0t: capture_done fell while enable_bram stayed high",
					$time);
				n_errors++;
			end
		end
		done_prev = capture_done;
	end

endmodule

/* test/tb_adc_snapshot.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ADC snapshot testbench
// snapshot capture, hold, re-arm and result logging with buffer readback
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tb_adc_snapshot
	import adc_pkg::*;
();

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 5;
	localparam int IDLE_CYCLES = 50;
	localparam int HOLD_CYCLES = 200;
	localparam int N_RESULTS = 300;
	localparam int N_RESTART = 20;
	localparam int MAX_GAP = 3;
	localparam int FILL_CYCLES = CAPTURE_LAT + SNAP_DEPTH + 8;
	localparam int READ_CYCLES = SNAP_DEPTH + 4;
	// all six tests back to back with worst case gaps
	localparam int TEST_CYCLES = 2 * RESET_CYCLES + IDLE_CYCLES
		+ 2 * (FILL_CYCLES + READ_CYCLES) + HOLD_CYCLES + READ_CYCLES
		+ (N_RESULTS + N_RESTART) * (MAX_GAP + 2) + 64;

	logic                  data_clk_div;
	logic                  reset;
	logic [ADC_WORD_W-1:0] adc0_data;
	logic [ADC_WORD_W-1:0] adc1_data;
	logic                  enable_bram;
	logic                  corr_valid;
	logic [RESULT_W-1:0]   corr_aa;
	logic [RESULT_W-1:0]   corr_bb;
	addr_t                 snap_rd_addr;
	sample_pair_t          snap_rd_data;
	addr_t                 result_rd_addr;
	result_pair_t          result_rd_data;
	logic                  capture_done;

	logic snap_rd_en;
	logic result_rd_en;
	logic test_end;
	int   test_id;
	int   checks;
	int   errors;
	int   fails;
	int   seed;

	initial data_clk_div = 1'b0;
	always #(CLK_PERIOD / 2) data_clk_div = ~data_clk_div;

	adc_snapshot_top i_adc_snapshot_top (.*);

	snapshot_checker i_snapshot_checker (.*);

	task automatic drive_samples();
		adc0_data = ADC_WORD_W'($random(seed));
		adc1_data = ADC_WORD_W'($random(seed));
	endtask

	task automatic capture_snapshot();
		int waited;
		waited = 0;
		@(negedge data_clk_div);
		drive_samples();
		enable_bram = 1'b1;	// next rising edge is E
		@(negedge data_clk_div);
		while (capture_done !== 1'b1 && waited < FILL_CYCLES) begin
			drive_samples();
			waited++;
			@(negedge data_clk_div);
		end
		if (capture_done !== 1'b1) begin
			$display("capture_done never rose after enable_bram went high");
			fails++;
		end
	endtask

	task automatic drop_enable();
		int waited;
		waited = 0;
		@(negedge data_clk_div);
		enable_bram = 1'b0;
		@(negedge data_clk_div);
		while (capture_done !== 1'b0 && waited < 5) begin
			waited++;
			@(negedge data_clk_div);
		end
		if (capture_done !== 1'b0) begin
			$display("capture_done still high 5 cycles after enable_bram fell");
			fails++;
		end
	endtask

	task automatic read_snapshot();
		for (int k = 0; k < SNAP_DEPTH; k++) begin
			@(negedge data_clk_div);
			snap_rd_addr = addr_t'(k);
			snap_rd_en = 1'b1;
		end
		@(negedge data_clk_div);
		snap_rd_en = 1'b0;
		@(negedge data_clk_div);
	endtask

	task automatic log_results(input int count);
		int gap;
		for (int i = 0; i < count; i++) begin
			gap = $random(seed) & MAX_GAP;	// zero gives back-to-back strobes
			repeat (gap) begin
				@(negedge data_clk_div);
				corr_valid = 1'b0;
			end
			@(negedge data_clk_div);
			corr_valid = 1'b1;
			corr_aa = $random(seed);
			corr_bb = $random(seed);
		end
		@(negedge data_clk_div);
		corr_valid = 1'b0;
	endtask

	task automatic read_results(input int count);
		for (int n = 0; n < count; n++) begin
			@(negedge data_clk_div);
			result_rd_addr = addr_t'(n);
			result_rd_en = 1'b1;
		end
		@(negedge data_clk_div);
		result_rd_en = 1'b0;
		@(negedge data_clk_div);
	endtask

	task automatic finish_test(input int id);
		@(negedge data_clk_div);
		test_id = id;
		test_end = 1'b1;
		@(negedge data_clk_div);
		test_end = 1'b0;
	endtask

	initial begin
		seed = 82;
		fails = 0;
		reset = 1'b1;
		adc0_data = '0;
		adc1_data = '0;
		enable_bram = 1'b0;
		corr_valid = 1'b0;
		corr_aa = '0;
		corr_bb = '0;
		snap_rd_addr = '0;
		result_rd_addr = '0;
		snap_rd_en = 1'b0;
		result_rd_en = 1'b0;
		test_end = 1'b0;
		test_id = 0;
		repeat (RESET_CYCLES) @(negedge data_clk_div);
		reset = 1'b0;

		repeat (IDLE_CYCLES) @(negedge data_clk_div);
		finish_test(1);

		capture_snapshot();
		read_snapshot();
		finish_test(2);

		// new data must not land while still enabled
		repeat (HOLD_CYCLES) begin
			@(negedge data_clk_div);
			drive_samples();
		end
		read_snapshot();
		finish_test(3);

		drop_enable();
		repeat (10) @(negedge data_clk_div);
		capture_snapshot();
		read_snapshot();
		finish_test(4);

		log_results(N_RESULTS);
		read_results(N_RESULTS);
		finish_test(5);

		drop_enable();
		@(negedge data_clk_div);
		reset = 1'b1;
		repeat (RESET_CYCLES) @(negedge data_clk_div);
		reset = 1'b0;
		log_results(N_RESTART);
		read_results(N_RESTART);
		finish_test(6);

		@(negedge data_clk_div);
		$display("total: %0d checks, %0d errors, %0d other failures", checks, errors, fails);
		if (errors == 0 && fails == 0 && checks > 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	initial begin
		#(2 * TEST_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, the run did not finish", 2 * TEST_CYCLES);
		$display("Done: errors found");
		$finish;
	end

endmodule
